/* sim.f */
source/stream_pkg.sv
source/burst_pkg.sv
source/stream_fifo.sv
source/burst_chop.sv
source/burst_sequencer.sv
source/burst_splitter_top.sv
verification/burst_splitter_checker.sv
verification/burst_splitter_tb.sv

/* Makefile */
TOP = burst_splitter_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
	  echo "Simulation failed, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* verification/burst_splitter_tb.sv */
module burst_splitter_tb;

  import stream_pkg::*;
  import burst_pkg::*;

  localparam int CLOCK_PERIOD = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ROWS = 10;

  // Packet beats, burst limit and bursts expected on the output
  typedef struct packed {
    int packet_beats;
    int burst_limit;
    int bursts;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{3, 8, 1},
    '{8, 4, 2},
    '{10, 4, 3},
    '{5, 1, 5},
    '{20, 16, 2},
    '{16, 16, 1},
    '{1, 5, 1},
    '{13, 3, 5},
    '{33, 16, 3},
    '{6, 2, 3}
  };

  logic clock;
  logic reset;
  logic s_tvalid;
  logic s_tready;
  logic s_tlast;
  data_t s_tdata;
  logic m_tvalid;
  logic m_tready;
  logic m_tlast;
  data_t m_tdata;
  logic desc_valid;
  logic desc_ready;
  length_t desc_length;
  logic desc_end;
  length_t burst_length;

  data_t send_q[$];
  data_t expect_data_q[$];
  logic expect_last_q[$];
  burst_desc_t expect_desc_q[$];
  burst_desc_t expected_desc;
  int beats_seen = 0;
  int lasts_seen = 0;
  int errors = 0;
  int checks = 0;

  burst_splitter_top #(
    .DATA_WIDTH(DATA_WIDTH),
    .MAX_LENGTH(MAX_LENGTH),
    .FIFO_DEPTH(8)
  ) i_burst_splitter_top (
    .clock         (clock),
    .reset         (reset),
    .s_tvalid_i    (s_tvalid),
    .s_tready_o    (s_tready),
    .s_tlast_i     (s_tlast),
    .s_tdata_i     (s_tdata),
    .m_tvalid_o    (m_tvalid),
    .m_tready_i    (m_tready),
    .m_tlast_o     (m_tlast),
    .m_tdata_o     (m_tdata),
    .desc_valid_o  (desc_valid),
    .desc_ready_i  (desc_ready),
    .desc_length_o (desc_length),
    .desc_end_o    (desc_end),
    .burst_length_i(burst_length)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  task automatic compare(input int actual, input int expected, input string what);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // Full bursts of the limit, then whatever remains of the packet
  task automatic build_packet(input int beats, input int limit);
    int i;
    int remaining;
    int size;
    data_t value;
    for (i = 0; i < beats; i++) begin
      value = data_t'($urandom);
      send_q.push_back(value);
      expect_data_q.push_back(value);
      expect_last_q.push_back(((i + 1) % limit == 0) || (i == beats - 1));
    end
    remaining = beats;
    while (remaining > 0) begin
      size = (remaining < limit) ? remaining : limit;
      expect_desc_q.push_back('{length: length_t'(size), ends_packet: size == remaining});
      remaining -= size;
    end
  endtask

  task automatic send_packet();
    s_tvalid = 1'b1;
    while (send_q.size() != 0) begin
      s_tdata = send_q.pop_front();
      s_tlast = send_q.size() == 0;
      // Ready seen at the falling edge means the next rising edge takes the beat
      @(negedge clock);
      while (!s_tready) begin
        @(negedge clock);
      end
      @(posedge clock);
      #1;
    end
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
  endtask

  // Random back-pressure on both consumers
  always begin
    @(posedge clock);
    #1;
    m_tready = $urandom_range(3) != 0;
    desc_ready = $urandom_range(3) != 0;
  end

  always @(negedge clock) begin
    if (!reset && m_tvalid && m_tready) begin
      if (expect_data_q.size() == 0) begin
        errors++;
        $display("Output beat at %0t arrived while no beat was expected", $time);
      end else begin
        compare(int'(m_tdata), int'(expect_data_q.pop_front()), "output data");
        compare(int'(m_tlast), int'(expect_last_q.pop_front()), "output last");
      end
      beats_seen++;
      if (m_tlast) begin
        lasts_seen++;
      end
    end
  end

  always @(negedge clock) begin
    if (!reset && desc_valid && desc_ready) begin
      if (expect_desc_q.size() == 0) begin
        errors++;
        $display("Descriptor at %0t arrived while no burst was outstanding", $time);
      end else begin
        expected_desc = expect_desc_q.pop_front();
        compare(int'(desc_length), int'(expected_desc.length), "descriptor length");
        compare(int'(desc_end), int'(expected_desc.ends_packet), "descriptor end of packet");
      end
    end
  end

  initial begin
    int row;
    int target;
    int lasts_before;
    void'($urandom(32));
    clock = 1'b0;
    reset = 1'b1;
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
    s_tdata = '0;
    m_tready = 1'b0;
    desc_ready = 1'b0;
    burst_length = length_t'(ROWS[0].burst_limit);
    target = 0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    compare(int'(s_tready), 0, "input ready at reset release");
    compare(int'(m_tvalid), 0, "output valid after reset");
    compare(int'(desc_valid), 0, "descriptor valid after reset");
    // Input FIFO is empty, so ready rises one cycle after reset falls
    @(posedge clock);
    #1;
    compare(int'(s_tready), 1, "input ready one cycle after reset");
    for (row = 0; row < NUM_ROWS; row++) begin
      // New limit lands before the sequencer re-arms after the previous packet
      @(posedge clock);
      #1;
      burst_length = length_t'(ROWS[row].burst_limit);
      lasts_before = lasts_seen;
      target += ROWS[row].packet_beats;
      build_packet(ROWS[row].packet_beats, ROWS[row].burst_limit);
      send_packet();
      wait (beats_seen == target);
      compare(lasts_seen - lasts_before, ROWS[row].bursts, "bursts per packet");
    end
    while (expect_desc_q.size() != 0) begin
      @(posedge clock);
    end
    // Leave room for any stray beat or descriptor to show up
    repeat (20) @(posedge clock);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    int total_beats;
    int row;
    total_beats = 0;
    for (row = 0; row < NUM_ROWS; row++) begin
      total_beats += ROWS[row].packet_beats;
    end
    #((RESET_CYCLES + total_beats * 20) * CLOCK_PERIOD);
    $display("Timeout: the DUT did not deliver every expected beat and descriptor in time");
    $display("Test FAILED");
    $finish;
  end

endmodule

/* verification/burst_splitter_checker.sv */
module burst_splitter_checker #(
  parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH
) (
  input logic                  clock,
  input logic                  reset,
  input logic                  s_tready_i,
  input logic                  m_tvalid_i,
  input logic                  m_tready_i,
  input logic                  m_tlast_i,
  input logic [DATA_WIDTH-1:0] m_tdata_i,
  input logic                  desc_valid_i,
  input logic                  desc_ready_i
);

  // A stalled output beat keeps its valid, data and last
  output_held: assert property (@(posedge clock) disable iff (reset)
    (m_tvalid_i && !m_tready_i) |=> (m_tvalid_i && $stable(m_tdata_i) && $stable(m_tlast_i)))
    else $error("Output beat changed while the consumer stalled it");

  // A stalled descriptor stays offered
  desc_held: assert property (@(posedge clock) disable iff (reset)
    (desc_valid_i && !desc_ready_i) |=> desc_valid_i)
    else $error("Descriptor valid dropped while the consumer stalled it");

  // Input FIFO refuses beats while reset is held
  ready_in_reset: assert property (@(posedge clock)
    (reset && $past(reset)) |-> !s_tready_i)
    else $error("Input ready was high during reset");

endmodule

bind burst_splitter_top burst_splitter_checker #(
  .DATA_WIDTH(DATA_WIDTH)
) i_checker (
  .clock       (clock),
  .reset       (reset),
  .s_tready_i  (s_tready_o),
  .m_tvalid_i  (m_tvalid_o),
  .m_tready_i  (m_tready_i),
  .m_tlast_i   (m_tlast_o),
  .m_tdata_i   (m_tdata_o),
  .desc_valid_i(desc_valid_o),
  .desc_ready_i(desc_ready_i)
);

/* source/burst_splitter_top.sv */
module burst_splitter_top #(
  parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH,
  parameter int MAX_LENGTH = burst_pkg::MAX_LENGTH,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  logic                  s_tlast_i,
  input  logic [DATA_WIDTH-1:0] s_tdata_i,

  output logic                  m_tvalid_o,
  input  logic                  m_tready_i,
  output logic                  m_tlast_o,
  output logic [DATA_WIDTH-1:0] m_tdata_o,

  output logic                  desc_valid_o,
  input  logic                  desc_ready_i,
  output burst_pkg::length_t    desc_length_o,
  output logic                  desc_end_o,

  input  burst_pkg::length_t    burst_length_i
);

  import burst_pkg::*;

  // One buffered input beat
  typedef struct packed {
    logic                  last;
    logic [DATA_WIDTH-1:0] data;
  } beat_t;

  beat_t in_beat;
  beat_t out_beat;
  logic beat_valid;
  logic beat_ready;

  logic chop_active;
  length_t chop_length;
  logic chop_final;
  logic m_transfer;

  burst_desc_t desc_in;
  burst_desc_t desc_out;
  logic desc_in_valid;
  logic desc_in_ready;

  assign in_beat = '{last: s_tlast_i, data: s_tdata_i};
  assign m_transfer = m_tvalid_o && m_tready_i;
  assign desc_length_o = desc_out.length;
  assign desc_end_o = desc_out.ends_packet;

  stream_fifo #(
    .payload_t (beat_t),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_beat_fifo (
    .clock        (clock),
    .reset        (reset),
    .write_valid_i(s_tvalid_i),
    .write_ready_o(s_tready_o),
    .write_data_i (in_beat),
    .read_valid_o (beat_valid),
    .read_ready_i (beat_ready),
    .read_data_o  (out_beat)
  );

  burst_chop #(
    .MAX_LENGTH(MAX_LENGTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) i_burst_chop (
    .clock     (clock),
    .reset     (reset),
    .active_i  (chop_active),
    .length_i  (chop_length),
    .final_o   (chop_final),
    .s_tvalid_i(beat_valid),
    .s_tready_o(beat_ready),
    .s_tlast_i (out_beat.last),
    .s_tdata_i (out_beat.data),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

  burst_sequencer #(
    .MAX_LENGTH(MAX_LENGTH)
  ) i_burst_sequencer (
    .clock         (clock),
    .reset         (reset),
    .burst_length_i(burst_length_i),
    .active_o      (chop_active),
    .length_o      (chop_length),
    .final_i       (chop_final),
    .m_transfer_i  (m_transfer),
    .m_last_i      (m_tlast_o),
    .desc_valid_o  (desc_in_valid),
    .desc_ready_i  (desc_in_ready),
    .desc_data_o   (desc_in)
  );

  stream_fifo #(
    .payload_t (burst_desc_t),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_desc_fifo (
    .clock        (clock),
    .reset        (reset),
    .write_valid_i(desc_in_valid),
    .write_ready_o(desc_in_ready),
    .write_data_i (desc_in),
    .read_valid_o (desc_valid_o),
    .read_ready_i (desc_ready_i),
    .read_data_o  (desc_out)
  );

endmodule

/* source/burst_sequencer.sv */
module burst_sequencer #(
  parameter int MAX_LENGTH = burst_pkg::MAX_LENGTH
) (
  input  logic                   clock,
  input  logic                   reset,
  input  burst_pkg::length_t     burst_length_i,

  output logic                   active_o,
  output burst_pkg::length_t     length_o,

  input  logic                   final_i,
  input  logic                   m_transfer_i,
  input  logic                   m_last_i,

  output logic                   desc_valid_o,
  input  logic                   desc_ready_i,
  output burst_pkg::burst_desc_t desc_data_o
);

  import burst_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    DRAIN
  } state_t;

  state_t state_q;
  length_t length_q;
  length_t count_q;
  length_t count_next;
  length_t length_sample;
  logic burst_done;

  // Keep the requested length inside 1 to MAX_LENGTH
  always_comb begin
    if (burst_length_i == '0) begin
      length_sample = length_t'(1);
    end else if (burst_length_i > length_t'(MAX_LENGTH)) begin
      length_sample = length_t'(MAX_LENGTH);
    end else begin
      length_sample = burst_length_i;
    end
  end

  assign count_next = count_q + 1'b1;
  assign burst_done = (state_q == ARMED) && m_transfer_i && m_last_i;

  assign active_o = state_q == ARMED;
  assign length_o = length_q;

  // Descriptor goes out with the last output beat.
  // A short burst or a source last marks the end of the packet
  assign desc_valid_o = burst_done;
  assign desc_data_o.length = count_next;
  assign desc_data_o.ends_packet = final_i || (count_next != length_q);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      length_q <= '0;
      count_q <= '0;
    end else begin
      case (state_q)
        // Arm only when the descriptor FIFO has room for this burst
        IDLE, DRAIN: begin
          if (desc_ready_i) begin
            state_q <= ARMED;
            length_q <= length_sample;
            count_q <= '0;
          end else begin
            state_q <= IDLE;
          end
        end
        ARMED: begin
          if (burst_done) begin
            state_q <= DRAIN;
          end else if (m_transfer_i) begin
            count_q <= count_next;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* source/burst_chop.sv */
module burst_chop #(
  parameter int MAX_LENGTH = burst_pkg::MAX_LENGTH,
  parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH
) (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  active_i,
  input  burst_pkg::length_t    length_i,
  output logic                  final_o,

  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  logic                  s_tlast_i,
  input  stream_pkg::data_t     s_tdata_i,

  output logic                  m_tvalid_o,
  input  logic                  m_tready_i,
  output logic                  m_tlast_o,
  output logic [DATA_WIDTH-1:0] m_tdata_o
);

  // Cuts the accepted stream after length_i beats or at the source last.
  // Raise active_i with a valid length_i at least one cycle before data is
  // expected; drop it for a cycle to start the next burst.

  localparam int LBITS = $clog2(MAX_LENGTH + 1);

  logic [LBITS-1:0] remain_q;
  logic armed_q;
  logic frame_q;
  logic final_q;

  logic sready_q;
  logic mvalid_q;
  logic tvalid_q;
  logic mlast_q;
  logic tlast_q;
  logic [DATA_WIDTH-1:0] mdata_q;
  logic [DATA_WIDTH-1:0] tdata_q;

  logic s_accept;
  logic last_beat;
  logic final_beat;
  logic frame_next;
  logic tvalid_next;
  logic mvalid_next;
  logic load_m_src;
  logic load_m_tmp;
  logic load_t;

  assign s_tready_o = sready_q;
  assign m_tvalid_o = mvalid_q;
  assign m_tlast_o = mlast_q;
  assign m_tdata_o = mdata_q;

  // High once the closing beat of this burst carried the source last
  assign final_o = final_q;

  assign s_accept = s_tvalid_i && sready_q;
  assign last_beat = (remain_q == LBITS'(1)) || s_tlast_i;
  assign final_beat = s_accept && last_beat;

  // Burst counter
  always_ff @(posedge clock) begin
    if (reset) begin
      armed_q <= 1'b0;
      remain_q <= '0;
      final_q <= 1'b0;
    end else begin
      armed_q <= active_i;
      // Length is taken on the first active cycle of each arming
      if (active_i && !armed_q) begin
        remain_q <= LBITS'(length_i);
      end else if (s_accept) begin
        remain_q <= remain_q - 1'b1;
      end
      if (!active_i) begin
        final_q <= 1'b0;
      end else if (final_beat && s_tlast_i) begin
        final_q <= 1'b1;
      end
    end
  end

  // Framer: one burst per arming, closed by the final beat
  assign frame_next = active_i && (!armed_q || (frame_q && !final_beat));

  always_ff @(posedge clock) begin
    if (reset) begin
      frame_q <= 1'b0;
    end else begin
      frame_q <= frame_next;
    end
  end

  // Ready and valid control of the M and T registers
  assign load_m_src = s_accept && (!mvalid_q || m_tready_i);
  assign load_t = s_accept && mvalid_q && !m_tready_i;
  assign load_m_tmp = tvalid_q && m_tready_i;
  assign tvalid_next = load_t || (tvalid_q && !m_tready_i);
  assign mvalid_next = s_accept || tvalid_q || (mvalid_q && !m_tready_i);

  always_ff @(posedge clock) begin
    if (reset) begin
      sready_q <= 1'b0;
      mvalid_q <= 1'b0;
      tvalid_q <= 1'b0;
    end else begin
      // Only accept while the frame is open and T has room
      sready_q <= frame_next && !tvalid_next;
      mvalid_q <= mvalid_next;
      tvalid_q <= tvalid_next;
    end
  end

  // Datapath
  always_ff @(posedge clock) begin
    if (load_m_src) begin
      mdata_q <= DATA_WIDTH'(s_tdata_i);
      mlast_q <= last_beat;
    end else if (load_m_tmp) begin
      mdata_q <= tdata_q;
      mlast_q <= tlast_q;
    end
    // Skid slot while the output is stalled
    if (load_t) begin
      tdata_q <= DATA_WIDTH'(s_tdata_i);
      tlast_q <= last_beat;
    end
  end

endmodule

/* source/stream_fifo.sv */
module stream_fifo #(
  parameter type payload_t = logic,
  parameter int FIFO_DEPTH = 8
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     write_valid_i,
  output logic     write_ready_o,
  input  payload_t write_data_i,
  output logic     read_valid_o,
  input  logic     read_ready_i,
  output payload_t read_data_o
);

  localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

  payload_t mem [FIFO_DEPTH];
  logic [PTR_BITS-1:0] write_ptr_q;
  logic [PTR_BITS-1:0] read_ptr_q;
  logic [COUNT_BITS-1:0] count_q;
  logic [COUNT_BITS-1:0] count_next;
  logic write_ready_q;
  logic do_write;
  logic do_read;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_write = write_valid_i && write_ready_q;
  assign do_read = read_valid_o && read_ready_i;
  assign read_valid_o = count_q != '0;
  assign read_data_o = mem[read_ptr_q];
  assign write_ready_o = write_ready_q;

  // Fill level after this cycle's transfers
  always_comb begin
    count_next = count_q;
    if (do_write && !do_read) begin
      count_next = count_q + 1'b1;
    end else if (do_read && !do_write) begin
      count_next = count_q - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      write_ptr_q <= '0;
      read_ptr_q <= '0;
      count_q <= '0;
      write_ready_q <= 1'b0;
    end else begin
      count_q <= count_next;
      // Registered, so ready stays low through reset
      write_ready_q <= count_next != COUNT_BITS'(FIFO_DEPTH);
      if (do_write) begin
        write_ptr_q <= next_ptr(write_ptr_q);
      end
      if (do_read) begin
        read_ptr_q <= next_ptr(read_ptr_q);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_write) begin
      mem[write_ptr_q] <= write_data_i;
    end
  end

endmodule

/* source/burst_pkg.sv */
package burst_pkg;

  // Largest burst the chopper is built for
  parameter int MAX_LENGTH = 16;

  // Wide enough for every count from 0 up to MAX_LENGTH
  parameter int LENGTH_BITS = $clog2(MAX_LENGTH + 1);

  typedef logic [LENGTH_BITS-1:0] length_t;

  // One record per output burst
  typedef struct packed {
    length_t length;
    // Set when this burst closed the input packet
    logic    ends_packet;
  } burst_desc_t;

endpackage

/* source/stream_pkg.sv */
package stream_pkg;

  // Default width of one stream beat
  parameter int DATA_WIDTH = 8;

  // One data word as it travels on the byte stream
  typedef logic [DATA_WIDTH-1:0] data_t;

endpackage
